/* Bender.yml */
package:
  name: net_core

sources:
  - common/core_pkg.sv
  - hw/alu.sv
  - hw/reg_file.sv
  - hw/instr_mem.sv
  - hw/barrier_unit.sv
  - hw/core_control.sv
  - hw/core_top.sv
  - target: test
    files:
      - test/core_tb.sv

/* common/core_pkg.sv */
package core_pkg;

    // Instruction layout is opcode [15:10], rd [9:5], rs_imm [4:0]
    localparam int instr_width    = 16;
    localparam int opcode_width   = 6;
    localparam int reg_addr_width = 5;

    // Field positions inside an instruction
    localparam int rs_imm_lsb     = 0;
    localparam int rd_lsb         = rs_imm_lsb + reg_addr_width;
    localparam int opcode_lsb     = rd_lsb + reg_addr_width;

    // Register file and network payload width
    localparam int data_width     = 32;

    // Barrier mask and value
    localparam int barrier_width  = 8;

    // Packet header fields
    localparam int net_id_width   = 10;
    localparam int net_addr_width = 10;

    // Reduced ISA
    // Codes outside this list execute as no-ops
    typedef enum logic [opcode_width-1:0] {
        ADDU  = 6'b000000,
        SUBU  = 6'b000001,
        AND   = 6'b000010,
        OR    = 6'b000011,
        MOV   = 6'b000100,
        BEQZ  = 6'b010000,
        BNEQZ = 6'b010001,
        JALR  = 6'b011000,
        BAR   = 6'b100000,
        DONE  = 6'b100001
    } opcode_e;

    // Core run state
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        RUN  = 2'b01,
        ERR  = 2'b10
    } state_e;

    // Packet operations
    typedef enum logic [2:0] {
        NET_NULL  = 3'd0,
        NET_INSTR = 3'd1,
        NET_REG   = 3'd2,
        NET_PC    = 3'd3,
        NET_BAR   = 3'd4
    } net_op_e;

endpackage

/* filelist.f */
common/core_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/instr_mem.sv
hw/barrier_unit.sv
hw/core_control.sv
hw/core_top.sv
test/core_tb.sv

/* hw/alu.sv */
`timescale 1ns/100ps

module alu
(
    input  core_pkg::opcode_e               op_i,
    input  logic [core_pkg::data_width-1:0] rd_val_i,
    input  logic [core_pkg::data_width-1:0] rs_val_i,
    output logic [core_pkg::data_width-1:0] result_o,
    output logic                            taken_o
);

    always_comb
    begin
        result_o = '0;
        taken_o  = 1'b0;
        case (op_i)
            // Two operand ops, rd is also the first source
            core_pkg::ADDU:
                result_o = rd_val_i + rs_val_i;
            core_pkg::SUBU:
                result_o = rd_val_i - rs_val_i;
            core_pkg::AND:
                result_o = rd_val_i & rs_val_i;
            core_pkg::OR:
                result_o = rd_val_i | rs_val_i;
            // rs passes straight through
            core_pkg::MOV, core_pkg::BAR, core_pkg::JALR:
                result_o = rs_val_i;
            // Branch conditions test rd
            core_pkg::BEQZ:
                taken_o = (rd_val_i == '0);
            core_pkg::BNEQZ:
                taken_o = (rd_val_i != '0);
            default:
                result_o = '0;
        endcase
    end

endmodule

/* hw/barrier_unit.sv */
`timescale 1ns/100ps

module barrier_unit
(
    input  logic                               clk,
    input  logic                               n_reset,
    input  core_pkg::state_e                   state_i,
    input  logic                               net_bar_write_i,
    input  logic                               net_pc_write_i,
    input  logic [core_pkg::data_width-1:0]    net_data_i,
    input  logic                               bar_commit_i,
    input  logic [core_pkg::data_width-1:0]    bar_val_i,
    output logic [core_pkg::barrier_width-1:0] barrier_o
);

    // A 1 in the mask lets the value bit through
    logic [core_pkg::barrier_width-1:0] mask_r;
    logic [core_pkg::barrier_width-1:0] value_r;

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            mask_r  <= '0;
            value_r <= '0;
        end
        else
        begin
            // Mask is frozen once the core has faulted
            if (net_bar_write_i && (state_i != core_pkg::ERR))
                mask_r <= net_data_i[core_pkg::barrier_width-1:0];
            // Start packet seeds the value, BAR updates it while running
            if (net_pc_write_i && (state_i == core_pkg::IDLE))
                value_r <= net_data_i[core_pkg::barrier_width-1:0];
            else if (bar_commit_i)
                value_r <= bar_val_i[core_pkg::barrier_width-1:0];
        end
    end

    assign barrier_o = mask_r & value_r;

endmodule

/* hw/core_control.sv */
`timescale 1ns/100ps

module core_control #(
    parameter int imem_addr_width_p = 8
)
(
    input  logic                                clk,
    input  logic                                n_reset,
    // Instruction in execute, taken from the memory output register
    input  logic [core_pkg::instr_width-1:0]    instr_i,
    input  logic                                taken_i,
    input  logic [core_pkg::data_width-1:0]     rs_val_i,
    // Network commands, already matched against the core ID
    input  logic                                net_pc_write_i,
    input  logic [core_pkg::net_addr_width-1:0] net_addr_i,
    input  logic                                net_instr_write_i,
    input  logic                                net_reg_write_i,
    output logic [imem_addr_width_p-1:0]        fetch_addr_o,
    output logic                                rf_wen_o,
    output logic                                rf_wdata_sel_jalr_o,
    output logic [core_pkg::data_width-1:0]     pc_plus1_o,
    output logic                                bar_commit_o,
    output logic                                exception_o,
    output logic [imem_addr_width_p-1:0]        pc_o,
    output core_pkg::state_e                    state_o
);

    // Fetch PC, i.e. the next address to read
    logic [imem_addr_width_p-1:0]        pc_r;
    logic [imem_addr_width_p-1:0]        pc_n;
    // Address and valid bit of the instruction now in execute
    logic [imem_addr_width_p-1:0]        exec_pc_r;
    logic [imem_addr_width_p-1:0]        exec_pc_n;
    logic                                exec_valid_r;
    logic                                exec_valid_n;
    core_pkg::state_e                    state_r;
    core_pkg::state_e                    state_n;
    logic                                exception_r;

    // Decode
    core_pkg::opcode_e                   opcode;
    logic [core_pkg::reg_addr_width-1:0] rs_imm;
    logic [imem_addr_width_p-1:0]        branch_target;
    logic                                op_writes_rf;
    logic                                op_is_branch;
    logic                                op_is_jalr;
    logic                                op_is_bar;
    logic                                op_is_done;

    logic                                exec_stall;
    logic                                exec_fire;
    logic                                redirect;

    assign opcode = core_pkg::opcode_e'(instr_i[core_pkg::opcode_lsb +: core_pkg::opcode_width]);
    assign rs_imm = instr_i[core_pkg::rs_imm_lsb +: core_pkg::reg_addr_width];

    always_comb
    begin
        op_writes_rf = 1'b0;
        op_is_branch = 1'b0;
        op_is_jalr   = 1'b0;
        op_is_bar    = 1'b0;
        op_is_done   = 1'b0;
        case (opcode)
            core_pkg::ADDU, core_pkg::SUBU, core_pkg::AND, core_pkg::OR, core_pkg::MOV:
                op_writes_rf = 1'b1;
            core_pkg::BEQZ, core_pkg::BNEQZ:
                op_is_branch = 1'b1;
            core_pkg::JALR:
            begin
                // Writes the link and jumps
                op_writes_rf = 1'b1;
                op_is_jalr   = 1'b1;
            end
            core_pkg::BAR:
                op_is_bar = 1'b1;
            core_pkg::DONE:
                op_is_done = 1'b1;
            default:
                op_writes_rf = 1'b0;
        endcase
    end

    // Network register write collides with an instruction write back
    assign exec_stall = net_reg_write_i && exec_valid_r && op_writes_rf;
    assign exec_fire  = exec_valid_r && !exec_stall;
    assign redirect   = exec_fire && (op_is_jalr || (op_is_branch && taken_i));

    // Branch offset is relative to the branch's own address
    assign branch_target = exec_pc_r
        + {{(imem_addr_width_p - core_pkg::reg_addr_width){rs_imm[core_pkg::reg_addr_width-1]}},
           rs_imm};

    always_comb
    begin
        state_n      = state_r;
        pc_n         = pc_r;
        exec_pc_n    = exec_pc_r;
        exec_valid_n = 1'b0;
        fetch_addr_o = pc_r;
        case (state_r)
            core_pkg::IDLE:
            begin
                // Start packet, first fetch happens in RUN
                if (net_pc_write_i)
                begin
                    pc_n    = net_addr_i[imem_addr_width_p-1:0];
                    state_n = core_pkg::RUN;
                end
            end
            core_pkg::RUN:
            begin
                if (net_pc_write_i)
                    state_n = core_pkg::ERR;
                else if (exec_stall)
                begin
                    // Read the held instruction again so it sits in execute next cycle
                    fetch_addr_o = exec_pc_r;
                    exec_valid_n = 1'b1;
                end
                else if (redirect)
                    // The slot fetched this cycle is dropped
                    pc_n = op_is_jalr ? rs_val_i[imem_addr_width_p-1:0] : branch_target;
                else if (exec_fire && op_is_done)
                    state_n = core_pkg::IDLE;
                else if (!net_instr_write_i)
                begin
                    pc_n         = pc_r + 1'b1;
                    exec_pc_n    = pc_r;
                    exec_valid_n = 1'b1;
                end
                // Memory port busy with a network write, fetch waits
            end
            default:
                // Only reset leaves ERR
                state_n = core_pkg::ERR;
        endcase
    end

    assign rf_wen_o            = exec_fire && op_writes_rf;
    assign rf_wdata_sel_jalr_o = op_is_jalr;
    assign pc_plus1_o          = {{(core_pkg::data_width - imem_addr_width_p){1'b0}}, exec_pc_r}
                                 + 1'b1;
    assign bar_commit_o        = exec_fire && op_is_bar;

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            state_r      <= core_pkg::IDLE;
            pc_r         <= '0;
            exec_valid_r <= 1'b0;
            exception_r  <= 1'b0;
        end
        else
        begin
            state_r      <= state_n;
            pc_r         <= pc_n;
            exec_valid_r <= exec_valid_n;
            // Sticky, start packet while busy or halted
            if (net_pc_write_i && (state_r != core_pkg::IDLE))
                exception_r <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        exec_pc_r <= exec_pc_n;
    end

    assign exception_o = exception_r;
    assign pc_o        = pc_r;
    assign state_o     = state_r;

endmodule

/* hw/core_top.sv */
`timescale 1ns/100ps

module core_top #(
    parameter int                                imem_addr_width_p = 8,
    parameter logic [core_pkg::net_id_width-1:0] net_id_p          = 1
)
(
    input  logic                                clk,
    input  logic                                n_reset,
    input  logic [core_pkg::net_id_width-1:0]   net_id_i,
    input  core_pkg::net_op_e                   net_op_i,
    input  logic [core_pkg::net_addr_width-1:0] net_addr_i,
    input  logic [core_pkg::data_width-1:0]     net_data_i,
    output logic [core_pkg::barrier_width-1:0]  barrier_o,
    output logic                                exception_o,
    output logic [imem_addr_width_p-1:0]        pc_o,
    output core_pkg::state_e                    state_o
);

    // Packet decode
    logic                                id_match;
    logic                                net_instr_write;
    logic                                net_reg_write;
    logic                                net_pc_write;
    logic                                net_bar_write;

    // Instruction memory side
    logic [imem_addr_width_p-1:0]        fetch_addr;
    logic [imem_addr_width_p-1:0]        imem_addr;
    logic [core_pkg::instr_width-1:0]    instr;
    core_pkg::opcode_e                   exec_op;

    // Register file and ALU
    logic [core_pkg::reg_addr_width-1:0] rd_addr;
    logic [core_pkg::reg_addr_width-1:0] rs_addr;
    logic [core_pkg::data_width-1:0]     rd_val;
    logic [core_pkg::data_width-1:0]     rs_val;
    logic [core_pkg::data_width-1:0]     alu_result;
    logic                                taken;
    logic                                rf_wen;
    logic [core_pkg::reg_addr_width-1:0] rf_waddr;
    logic [core_pkg::data_width-1:0]     rf_wdata;

    // From control
    logic                                core_rf_wen;
    logic                                rf_wdata_sel_jalr;
    logic [core_pkg::data_width-1:0]     pc_plus1;
    logic                                bar_commit;

    // Only packets carrying this core's ID count
    assign id_match        = (net_id_i == net_id_p);
    assign net_instr_write = id_match && (net_op_i == core_pkg::NET_INSTR);
    assign net_reg_write   = id_match && (net_op_i == core_pkg::NET_REG);
    assign net_pc_write    = id_match && (net_op_i == core_pkg::NET_PC);
    assign net_bar_write   = id_match && (net_op_i == core_pkg::NET_BAR);

    // Network write takes the memory port from fetch
    assign imem_addr = net_instr_write ? net_addr_i[imem_addr_width_p-1:0] : fetch_addr;

    // Memory output register is the execute stage instruction
    assign exec_op = core_pkg::opcode_e'(instr[core_pkg::opcode_lsb +: core_pkg::opcode_width]);
    assign rd_addr = instr[core_pkg::rd_lsb +: core_pkg::reg_addr_width];
    assign rs_addr = instr[core_pkg::rs_imm_lsb +: core_pkg::reg_addr_width];

    // Network register write wins the write port
    assign rf_wen   = net_reg_write || core_rf_wen;
    assign rf_waddr = net_reg_write ? net_addr_i[core_pkg::reg_addr_width-1:0] : rd_addr;

    always_comb
    begin
        if (net_reg_write)
            rf_wdata = net_data_i;
        else if (rf_wdata_sel_jalr)
            // Link address
            rf_wdata = pc_plus1;
        else
            rf_wdata = alu_result;
    end

    core_control #(
        .imem_addr_width_p(imem_addr_width_p)
    ) ctrl (
        .clk                 (clk),
        .n_reset             (n_reset),
        .instr_i             (instr),
        .taken_i             (taken),
        .rs_val_i            (rs_val),
        .net_pc_write_i      (net_pc_write),
        .net_addr_i          (net_addr_i),
        .net_instr_write_i   (net_instr_write),
        .net_reg_write_i     (net_reg_write),
        .fetch_addr_o        (fetch_addr),
        .rf_wen_o            (core_rf_wen),
        .rf_wdata_sel_jalr_o (rf_wdata_sel_jalr),
        .pc_plus1_o          (pc_plus1),
        .bar_commit_o        (bar_commit),
        .exception_o         (exception_o),
        .pc_o                (pc_o),
        .state_o             (state_o)
    );

    instr_mem #(
        .addr_width_p(imem_addr_width_p)
    ) imem (
        .clk     (clk),
        .addr_i  (imem_addr),
        .wen_i   (net_instr_write),
        .instr_i (net_data_i[core_pkg::instr_width-1:0]),
        .instr_o (instr)
    );

    reg_file rf (
        .clk       (clk),
        .rd_addr_i (rd_addr),
        .rs_addr_i (rs_addr),
        .w_addr_i  (rf_waddr),
        .wen_i     (rf_wen),
        .w_data_i  (rf_wdata),
        .rd_val_o  (rd_val),
        .rs_val_o  (rs_val)
    );

    alu exec_alu (
        .op_i     (exec_op),
        .rd_val_i (rd_val),
        .rs_val_i (rs_val),
        .result_o (alu_result),
        .taken_o  (taken)
    );

    barrier_unit bar (
        .clk             (clk),
        .n_reset         (n_reset),
        .state_i         (state_o),
        .net_bar_write_i (net_bar_write),
        .net_pc_write_i  (net_pc_write),
        .net_data_i      (net_data_i),
        .bar_commit_i    (bar_commit),
        .bar_val_i       (rs_val),
        .barrier_o       (barrier_o)
    );

endmodule

/* hw/instr_mem.sv */
`timescale 1ns/100ps

module instr_mem #(
    parameter int addr_width_p = 8
)
(
    input  logic                             clk,
    input  logic [addr_width_p-1:0]          addr_i,
    input  logic                             wen_i,
    input  logic [core_pkg::instr_width-1:0] instr_i,
    output logic [core_pkg::instr_width-1:0] instr_o
);

    logic [core_pkg::instr_width-1:0] mem [2**addr_width_p];

    // One port, read data arrives on the next clock
    always_ff @(posedge clk)
    begin
        if (wen_i)
            mem[addr_i] <= instr_i;
        instr_o <= mem[addr_i];
    end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/100ps

module reg_file
(
    input  logic                                clk,
    input  logic [core_pkg::reg_addr_width-1:0] rd_addr_i,
    input  logic [core_pkg::reg_addr_width-1:0] rs_addr_i,
    input  logic [core_pkg::reg_addr_width-1:0] w_addr_i,
    input  logic                                wen_i,
    input  logic [core_pkg::data_width-1:0]     w_data_i,
    output logic [core_pkg::data_width-1:0]     rd_val_o,
    output logic [core_pkg::data_width-1:0]     rs_val_o
);

    // 32 general registers
    logic [core_pkg::data_width-1:0] regs [2**core_pkg::reg_addr_width];

    always_ff @(posedge clk)
    begin
        if (wen_i)
            regs[w_addr_i] <= w_data_i;
    end

    // Combinational reads, register 0 is hardwired to zero
    assign rd_val_o = (rd_addr_i == '0) ? '0 : regs[rd_addr_i];
    assign rs_val_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];

endmodule

/* test/core_tb.sv */
`timescale 1ns/100ps

module core_tb;

    localparam logic [9:0] own_id      = 10'd1;
    localparam logic [9:0] foreign_id  = 10'd37;
    // Ten times the longest program over all tests
    localparam int         cycle_limit = 20000;
    localparam int         model_steps = 4096;

    logic                 clk;
    logic                 n_reset;
    logic [9:0]           net_id_i;
    core_pkg::net_op_e    net_op_i;
    logic [9:0]           net_addr_i;
    logic [31:0]          net_data_i;
    logic [7:0]           barrier_o;
    logic                 exception_o;
    logic [7:0]           pc_o;
    core_pkg::state_e     state_o;

    // Program and register image shared by the loader and the ISA model
    logic [15:0]          prog [256];
    logic [31:0]          reg_image [32];
    logic [15:0]          lfsr;
    int                   cycle_count;
    int                   test_errs;
    int                   tests_passed;
    int                   tests_failed;

    core_top #(
        .imem_addr_width_p(8),
        .net_id_p         (own_id)
    ) dut (
        .clk         (clk),
        .n_reset     (n_reset),
        .net_id_i    (net_id_i),
        .net_op_i    (net_op_i),
        .net_addr_i  (net_addr_i),
        .net_data_i  (net_data_i),
        .barrier_o   (barrier_o),
        .exception_o (exception_o),
        .pc_o        (pc_o),
        .state_o     (state_o)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    // Run limit
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout after %0d cycles, the DUT never returned to idle", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    // Galois LFSR, one step per random bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++)
        begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [15:0] enc(input logic [5:0] op, input logic [4:0] rd,
                                        input logic [4:0] rs);
        return {op, rd, rs};
    endfunction

    // ISA reference model, runs from start_pc until DONE
    function automatic void run_model(input logic [7:0] start_pc, input logic [7:0] bar_init,
                                      output logic [7:0] bar_final,
                                      output logic [7:0] pc_final, output bit reached_done);
        logic [31:0] regs [32];
        logic [7:0]  pc;
        logic [7:0]  next_pc;
        logic [15:0] word;
        logic [5:0]  op;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [31:0] rd_v;
        logic [31:0] rs_v;
        int          i;
        int          steps;
        for (i = 0; i < 32; i++)
            regs[i] = reg_image[i];
        pc           = start_pc;
        bar_final    = bar_init;
        pc_final     = start_pc;
        reached_done = 1'b0;
        steps        = 0;
        while (!reached_done && steps < model_steps)
        begin
            word    = prog[pc];
            op      = word[15:10];
            rd      = word[9:5];
            rs      = word[4:0];
            rd_v    = (rd == 5'd0) ? 32'd0 : regs[rd];
            rs_v    = (rs == 5'd0) ? 32'd0 : regs[rs];
            next_pc = pc + 8'd1;
            steps++;
            case (op)
                core_pkg::ADDU:
                    regs[rd] = rd_v + rs_v;
                core_pkg::SUBU:
                    regs[rd] = rd_v - rs_v;
                core_pkg::AND:
                    regs[rd] = rd_v & rs_v;
                core_pkg::OR:
                    regs[rd] = rd_v | rs_v;
                core_pkg::MOV:
                    regs[rd] = rs_v;
                // Offset counts from the branch itself
                core_pkg::BEQZ:
                    if (rd_v == 32'd0)
                        next_pc = pc + {{3{rs[4]}}, rs};
                core_pkg::BNEQZ:
                    if (rd_v != 32'd0)
                        next_pc = pc + {{3{rs[4]}}, rs};
                core_pkg::JALR:
                begin
                    next_pc  = rs_v[7:0];
                    regs[rd] = {24'd0, pc} + 32'd1;
                end
                core_pkg::BAR:
                    bar_final = rs_v[7:0];
                core_pkg::DONE:
                begin
                    reached_done = 1'b1;
                    pc_final     = pc + 8'd1;
                end
                default:
                    next_pc = pc + 8'd1;
            endcase
            pc = next_pc;
        end
    endfunction

    task automatic check_val(input string sig, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("CHECK FAILED %s got %h expected %h", sig, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond)
        else
        begin
            $display("Failure: %s", what);
            test_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0)
        begin
            tests_passed++;
            $display("PASS  %s", name);
        end
        else
        begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", name, test_errs);
        end
        test_errs = 0;
    endtask

    // One packet for one cycle, then back to NET_NULL
    task automatic send_packet(input logic [9:0] id, input core_pkg::net_op_e op,
                               input logic [9:0] addr, input logic [31:0] data);
        @(negedge clk);
        net_id_i   = id;
        net_op_i   = op;
        net_addr_i = addr;
        net_data_i = data;
        @(negedge clk);
        net_op_i   = core_pkg::NET_NULL;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        n_reset = 1'b0;
        repeat (4)
            @(negedge clk);
        n_reset = 1'b1;
    endtask

    task automatic load_program(input logic [7:0] base, input int len);
        int i;
        for (i = 0; i < len; i++)
            send_packet(own_id, core_pkg::NET_INSTR, 10'(base + i), {16'd0, prog[base + i]});
    endtask

    task automatic load_regs();
        int i;
        for (i = 1; i < 8; i++)
            send_packet(own_id, core_pkg::NET_REG, 10'(i), reg_image[i]);
    endtask

    task automatic wait_idle();
        while (state_o != core_pkg::IDLE)
            @(negedge clk);
    endtask

    // Start at base, wait for DONE, compare against the model
    task automatic run_and_check(input logic [7:0] base, input logic [7:0] mask);
        logic [7:0] bar_init;
        logic [7:0] exp_bar;
        logic [7:0] exp_pc;
        bit         ok;
        bar_init = rand_bits(8);
        run_model(base, bar_init, exp_bar, exp_pc, ok);
        check_true(ok, "reference model did not reach DONE");
        send_packet(own_id, core_pkg::NET_PC, {2'b00, base}, {24'd0, bar_init});
        wait_idle();
        check_val("barrier_o", barrier_o, mask & exp_bar);
        check_val("pc_o", pc_o, exp_pc);
        check_val("exception_o", exception_o, 1'b0);
    endtask

    // Random straight line program of ALU ops ending in BAR and DONE
    task automatic build_alu_program(input logic [7:0] base);
        logic [5:0] op;
        int         i;
        for (i = 1; i < 8; i++)
            reg_image[i] = rand_bits(32);
        for (i = 0; i < 12; i++)
        begin
            case (rand_bits(3) % 5)
                0:       op = core_pkg::ADDU;
                1:       op = core_pkg::SUBU;
                2:       op = core_pkg::AND;
                3:       op = core_pkg::OR;
                default: op = core_pkg::MOV;
            endcase
            prog[base + i] = enc(op, 5'(1 + rand_bits(3) % 6), 5'(rand_bits(3) % 7));
        end
        prog[base + 12] = enc(core_pkg::BAR, 5'd0, 5'(1 + rand_bits(3) % 6));
        prog[base + 13] = enc(core_pkg::DONE, 5'd0, 5'd0);
        load_program(base, 14);
        load_regs();
    endtask

    initial
    begin
        logic [7:0] mask;
        int         i;
        n_reset      = 1'b0;
        net_id_i     = '0;
        net_op_i     = core_pkg::NET_NULL;
        net_addr_i   = '0;
        net_data_i   = '0;
        lfsr         = 16'd34922;
        cycle_count  = 0;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (i = 0; i < 32; i++)
            reg_image[i] = 32'd0;

        apply_reset();
        check_val("barrier_o", barrier_o, 8'h00);
        check_val("exception_o", exception_o, 1'b0);
        check_val("pc_o", pc_o, 8'h00);
        check_val("state_o", state_o, core_pkg::IDLE);
        finish_test("reset");

        send_packet(own_id, core_pkg::NET_BAR, 10'd0, 32'hFF);
        build_alu_program(8'h00);
        run_and_check(8'h00, 8'hFF);
        finish_test("arithmetic program");

        // Count r1 down, BAR on each pass, then BEQZ on r0 skips to DONE
        mask         = rand_bits(8);
        reg_image[1] = 1 + rand_bits(3);
        reg_image[2] = 32'd1;
        reg_image[3] = rand_bits(32);
        reg_image[4] = rand_bits(32);
        prog[8'h40]  = enc(core_pkg::ADDU, 5'd3, 5'd4);
        prog[8'h41]  = enc(core_pkg::BAR, 5'd0, 5'd3);
        prog[8'h42]  = enc(core_pkg::SUBU, 5'd1, 5'd2);
        prog[8'h43]  = enc(core_pkg::BNEQZ, 5'd1, 5'b11101);
        prog[8'h44]  = enc(core_pkg::BEQZ, 5'd0, 5'd3);
        prog[8'h45]  = enc(core_pkg::MOV, 5'd3, 5'd0);
        prog[8'h46]  = enc(core_pkg::BAR, 5'd0, 5'd3);
        prog[8'h47]  = enc(core_pkg::DONE, 5'd0, 5'd0);
        load_program(8'h40, 8);
        load_regs();
        send_packet(own_id, core_pkg::NET_BAR, 10'd0, {24'd0, mask});
        run_and_check(8'h40, mask);
        finish_test("branches and masking");

        // Call through r5, the subroutine exposes the link in r6
        mask         = rand_bits(8);
        reg_image[5] = 32'h88;
        prog[8'h80]  = enc(core_pkg::JALR, 5'd6, 5'd5);
        prog[8'h81]  = enc(core_pkg::DONE, 5'd0, 5'd0);
        prog[8'h88]  = enc(core_pkg::BAR, 5'd0, 5'd6);
        prog[8'h89]  = enc(core_pkg::JALR, 5'd0, 5'd6);
        load_program(8'h80, 2);
        load_program(8'h88, 2);
        load_regs();
        send_packet(own_id, core_pkg::NET_BAR, 10'd0, {24'd0, mask});
        run_and_check(8'h80, mask);
        check_val("barrier_o", barrier_o, mask & 8'h81);
        finish_test("jalr");

        // Foreign packets aimed at the program about to run
        mask = rand_bits(8);
        send_packet(own_id, core_pkg::NET_BAR, 10'd0, {24'd0, mask});
        build_alu_program(8'hC0);
        send_packet(foreign_id, core_pkg::NET_INSTR, 10'h0C0, {16'd0, prog[8'hCD]});
        send_packet(foreign_id, core_pkg::NET_REG, 10'd1, ~reg_image[1]);
        send_packet(foreign_id, core_pkg::NET_BAR, 10'd0, {24'd0, ~mask});
        send_packet(foreign_id, core_pkg::NET_PC, 10'h0C0, 32'h0);
        check_val("state_o", state_o, core_pkg::IDLE);
        // Value still holds the link exposed by the call test
        check_val("barrier_o", barrier_o, mask & 8'h81);
        // PC still rests one past the DONE of the call test
        check_val("pc_o", pc_o, 8'h82);
        run_and_check(8'hC0, mask);
        finish_test("foreign id packets");

        // Endless enough loop, then a second start packet
        reg_image[1] = 32'd1000;
        reg_image[2] = 32'd1;
        prog[8'hE0]  = enc(core_pkg::SUBU, 5'd1, 5'd2);
        prog[8'hE1]  = enc(core_pkg::BNEQZ, 5'd1, 5'b11111);
        prog[8'hE2]  = enc(core_pkg::DONE, 5'd0, 5'd0);
        load_program(8'hE0, 3);
        load_regs();
        send_packet(own_id, core_pkg::NET_BAR, 10'd0, 32'hFF);
        send_packet(own_id, core_pkg::NET_PC, 10'h0E0, 32'h5A);
        repeat (10)
            @(negedge clk);
        check_val("state_o", state_o, core_pkg::RUN);
        send_packet(own_id, core_pkg::NET_PC, 10'h0E0, 32'h33);
        check_val("exception_o", exception_o, 1'b1);
        check_val("state_o", state_o, core_pkg::ERR);
        // Loop has no BAR, value is still the start seed
        check_val("barrier_o", barrier_o, 8'h5A);
        send_packet(own_id, core_pkg::NET_BAR, 10'd0, 32'h0F);
        check_val("barrier_o", barrier_o, 8'h5A);
        apply_reset();
        check_val("exception_o", exception_o, 1'b0);
        check_val("state_o", state_o, core_pkg::IDLE);
        check_val("barrier_o", barrier_o, 8'h00);
        check_val("pc_o", pc_o, 8'h00);
        finish_test("exception");

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule
